// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TOP        ?= dcache_tb
FILELIST   ?= dcache.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== dcache.f ====
src/dcache_pkg.sv
src/dcache_dt.sv
src/dcache_rams.sv
src/dcache_ex.sv
src/dcache_fill.sv
src/dcache.sv
verif/dcache_properties.sv
verif/dcache_tb.sv

// ==== src/dcache.sv ====
// dcache top
// request, ram read and execute stages with stall control and the fill unit.

`timescale 1ns/1ns

module dcache (
    input  logic                                clk,
    input  logic                                i_rst,
    input  dcache_pkg::dc_req_t                 i_req,
    output logic                                o_ready,
    output dcache_pkg::dc_rsp_t                 o_rsp,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,
    output logic                                o_wb_we,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   o_wb_adr,
    output logic [dcache_pkg::DATA_WIDTH-1:0]   o_wb_dat,
    output logic [dcache_pkg::DATA_SIZE-1:0]    o_wb_sel,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]   i_wb_dat,
    input  logic                                i_wb_ack
);

    import dcache_pkg::*;

    dc_req_t                dt_req;
    dc_stage_t              dt_stage;
    dc_stage_t              rd_stage;
    dc_stage_t              ex_stage;
    dc_line_state_t         rd_state;
    logic [LINE_WIDTH-1:0]  rd_line;
    logic                   init_busy;
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    dc_line_state_t         wr_state;
    logic [LINE_WIDTH-1:0]  wr_line;
    logic                   miss;
    logic                   fill_start;
    dc_fill_req_t           fill_req;
    logic                   fill_done;
    logic [LINE_WIDTH-1:0]  fill_line;
    dc_addr_t               fill_addr;
    logic                   refresh;
    logic                   en;
    logic                   store_pending;

    assign store_pending = (dt_stage.valid && (dt_stage.op inside {op_sb, op_sh, op_sw})) ||
                           (rd_stage.valid && (rd_stage.op inside {op_sb, op_sh, op_sw}));
    assign en      = !init_busy && !miss && !refresh;
    assign o_ready = en && !fill_start && !store_pending;

    always_comb begin
        dt_req       = i_req;
        dt_req.valid = i_req.valid && o_ready;
    end

    // fill op goes straight from dt to ex, past the frozen rd stage.
    always_comb begin
        ex_stage       = dt_stage.fill ? dt_stage : rd_stage;
        ex_stage.valid = ex_stage.valid && !refresh;
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rd_stage <= dt_stage;
        end
        if (i_rst) begin
            rd_stage.valid <= 1'b0;
            rd_stage.fill  <= 1'b0;
            refresh        <= 1'b0;
        end else begin
            // rd stage re-reads its line once the fill is written.
            refresh <= dt_stage.fill;
        end
    end

    dcache_dt u_dt (
        .clk(clk), .i_rst(i_rst), .i_en(en || dt_stage.fill), .i_req(dt_req),
        .i_fill(fill_done), .i_fill_addr(fill_addr), .i_fill_data(fill_line),
        .o_stage(dt_stage)
    );

    dcache_rams u_rams (
        .clk(clk), .i_rst(i_rst),
        .i_rd_index(en ? dt_stage.addr.fields.index : rd_stage.addr.fields.index),
        .i_hold(!en && !refresh), .i_wr_en(wr_en), .i_wr_index(wr_index),
        .i_wr_state(wr_state), .i_wr_line(wr_line), .o_state(rd_state),
        .o_line(rd_line), .o_init_busy(init_busy)
    );

    dcache_ex u_ex (
        .clk(clk), .i_rst(i_rst), .i_stage(ex_stage), .i_state(rd_state),
        .i_line(rd_line), .i_fill_done(fill_done), .o_wr_en(wr_en),
        .o_wr_index(wr_index), .o_wr_state(wr_state), .o_wr_line(wr_line),
        .o_rsp(o_rsp), .o_miss(miss), .o_fill_start(fill_start), .o_fill_req(fill_req)
    );

    dcache_fill u_fill (
        .clk(clk), .i_rst(i_rst), .i_start(fill_start), .i_req(fill_req),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack), .o_done(fill_done),
        .o_line(fill_line), .o_addr(fill_addr)
    );

endmodule

// ==== src/dcache_dt.sv ====
// dcache request stage
// registers a cpu request or a line-fill write and derives the byte select.

`timescale 1ns/1ns

module dcache_dt (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                i_en,
    input  dcache_pkg::dc_req_t                 i_req,
    input  logic                                i_fill,
    input  dcache_pkg::dc_addr_t                i_fill_addr,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_fill_data,
    output dcache_pkg::dc_stage_t               o_stage
);

    import dcache_pkg::*;

    logic [DATA_SIZE-1:0] sel;
    dc_stage_t            req_stage;
    dc_stage_t            fill_stage;

    // lanes by access size, then moved to the byte offset.
    always_comb begin
        case (i_req.op)
            op_lb, op_lbu, op_sb: sel = 4'b0001;
            op_lh, op_lhu, op_sh: sel = 4'b0011;
            default:              sel = 4'b1111;
        endcase
    end

    always_comb begin
        req_stage.valid     = i_req.valid;
        req_stage.op        = i_req.op;
        req_stage.addr      = i_req.addr;
        req_stage.data      = i_req.data;
        req_stage.byte_sel  = sel << i_req.addr.fields.offset[1:0];
        req_stage.fill      = 1'b0;
        req_stage.fill_data = '0;

        fill_stage.valid     = 1'b1;
        fill_stage.op        = op_lw;
        fill_stage.addr      = i_fill_addr;
        fill_stage.data      = '0;
        fill_stage.byte_sel  = '1;
        fill_stage.fill      = 1'b1;
        fill_stage.fill_data = i_fill_data;
    end

    // fill write wins over a cpu request.
    always_ff @(posedge clk) begin
        if (i_fill) begin
            o_stage <= fill_stage;
        end else if (i_en) begin
            o_stage <= req_stage;
        end
        if (i_rst) begin
            o_stage.valid <= 1'b0;
            o_stage.fill  <= 1'b0;
        end
    end

endmodule

// ==== src/dcache_ex.sv ====
// dcache execute stage
// hit check, load extend, store merge, array write and miss hand-off.

`timescale 1ns/1ns

module dcache_ex (
    input  logic                                clk,
    input  logic                                i_rst,
    input  dcache_pkg::dc_stage_t               i_stage,
    input  dcache_pkg::dc_line_state_t          i_state,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_line,
    input  logic                                i_fill_done,
    output logic                                o_wr_en,
    output logic [dcache_pkg::INDEX_WIDTH-1:0]  o_wr_index,
    output dcache_pkg::dc_line_state_t          o_wr_state,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   o_wr_line,
    output dcache_pkg::dc_rsp_t                 o_rsp,
    output logic                                o_miss,
    output logic                                o_fill_start,
    output dcache_pkg::dc_fill_req_t            o_fill_req
);

    import dcache_pkg::*;

    logic                          miss_q;
    dc_stage_t                     hold_q;
    dc_stage_t                     cur;
    logic                          hit;
    logic                          op_now;
    logic                          miss_now;
    logic                          fill_in;
    logic                          complete;
    logic                          is_store;
    logic [LINE_WIDTH-1:0]         line;
    logic [OFFSET_WIDTH-3:0]       word_idx;
    logic [DATA_WIDTH-1:0]         word;
    logic [DATA_WIDTH-1:0]         lane;
    logic [DATA_WIDTH-1:0]         ld_data;
    logic [DATA_WIDTH-1:0]         st_word;
    logic [DATA_WIDTH-1:0]         merged;
    logic [LINE_WIDTH-1:0]         new_line;

    assign hit      = i_state.valid && (i_state.tag == i_stage.addr.fields.tag);
    assign op_now   = i_stage.valid && !i_stage.fill && !miss_q;
    assign miss_now = op_now && !hit;
    assign fill_in  = miss_q && i_stage.valid && i_stage.fill;
    assign complete = (op_now && hit) || fill_in;

    // while missing, the held op runs against the line being filled.
    assign cur      = miss_q ? hold_q : i_stage;
    assign line     = miss_q ? i_stage.fill_data : i_line;
    assign is_store = cur.op inside {op_sb, op_sh, op_sw};
    assign word_idx = cur.addr.fields.offset[OFFSET_WIDTH-1:2];
    assign word     = line[word_idx*DATA_WIDTH +: DATA_WIDTH];
    assign lane     = word >> {cur.addr.fields.offset[1:0], 3'b000};
    assign st_word  = cur.data << {cur.addr.fields.offset[1:0], 3'b000};

    always_comb begin
        case (cur.op)
            op_lb:   ld_data = {{24{lane[7]}}, lane[7:0]};
            op_lbu:  ld_data = {24'b0, lane[7:0]};
            op_lh:   ld_data = {{16{lane[15]}}, lane[15:0]};
            op_lhu:  ld_data = {16'b0, lane[15:0]};
            default: ld_data = lane;
        endcase
    end

    always_comb begin
        for (int i = 0; i < DATA_SIZE; i++) begin
            merged[i*8 +: 8] = cur.byte_sel[i] ? st_word[i*8 +: 8] : word[i*8 +: 8];
        end
        new_line = line;
        new_line[word_idx*DATA_WIDTH +: DATA_WIDTH] = merged;
    end

    assign o_wr_en          = fill_in || (op_now && hit && is_store);
    assign o_wr_index       = i_stage.addr.fields.index;
    assign o_wr_state.valid = 1'b1;
    assign o_wr_state.dirty = is_store;
    assign o_wr_state.tag   = i_stage.addr.fields.tag;
    assign o_wr_line        = is_store ? new_line : line;

    assign o_miss       = miss_q;
    assign o_fill_start = miss_now;

    always_comb begin
        o_fill_req.victim_dirty               = i_state.valid && i_state.dirty;
        o_fill_req.victim_addr.fields.tag     = i_state.tag;
        o_fill_req.victim_addr.fields.index   = i_stage.addr.fields.index;
        o_fill_req.victim_addr.fields.offset  = '0;
        o_fill_req.miss_addr.fields.tag       = i_stage.addr.fields.tag;
        o_fill_req.miss_addr.fields.index     = i_stage.addr.fields.index;
        o_fill_req.miss_addr.fields.offset    = '0;
        o_fill_req.victim_line                = i_line;
    end

    always_ff @(posedge clk) begin
        o_rsp.data <= ld_data;
        if (miss_now) begin
            hold_q <= i_stage;
        end
        if (i_rst) begin
            miss_q      <= 1'b0;
            o_rsp.valid <= 1'b0;
        end else begin
            o_rsp.valid <= complete && !is_store;
            if (miss_now) begin
                miss_q <= 1'b1;
            end else if (fill_in) begin
                miss_q <= 1'b0;
            end
        end
    end

endmodule

// ==== src/dcache_fill.sv ====
// dcache line-fill unit
// wishbone classic master, writes back a dirty victim then reads the new line.

`timescale 1ns/1ns

module dcache_fill (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                i_start,
    input  dcache_pkg::dc_fill_req_t            i_req,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,
    output logic                                o_wb_we,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   o_wb_adr,
    output logic [dcache_pkg::DATA_WIDTH-1:0]   o_wb_dat,
    output logic [dcache_pkg::DATA_SIZE-1:0]    o_wb_sel,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]   i_wb_dat,
    input  logic                                i_wb_ack,
    output logic                                o_done,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   o_line,
    output dcache_pkg::dc_addr_t                o_addr
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wb, st_rd, st_done} fill_state_t;

    fill_state_t                    state;
    dc_fill_req_t                   req_q;
    dc_addr_t                       base;
    logic [$clog2(LINE_WORDS)-1:0]  beat;

    assign base     = (state == st_wb) ? req_q.victim_addr : req_q.miss_addr;
    assign o_wb_we  = (state == st_wb);
    assign o_wb_adr = {base.fields.tag, base.fields.index, beat, 2'b00};
    assign o_wb_dat = req_q.victim_line[beat*DATA_WIDTH +: DATA_WIDTH];
    assign o_wb_sel = '1;
    assign o_done   = (state == st_done);
    assign o_addr   = req_q.miss_addr;

    // one beat per cycle, strobe drops for a cycle after every ack.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= st_idle;
            beat     <= '0;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (i_start) begin
                        req_q <= i_req;
                        beat  <= '0;
                        state <= i_req.victim_dirty ? st_wb : st_rd;
                    end
                end
                st_wb, st_rd: begin
                    if (!o_wb_stb) begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                    end else if (i_wb_ack) begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        beat     <= beat + 1'b1;
                        if (state == st_rd) begin
                            o_line[beat*DATA_WIDTH +: DATA_WIDTH] <= i_wb_dat;
                        end
                        if (&beat) begin
                            state <= (state == st_wb) ? st_rd : st_done;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
// dcache package
// shared geometry, op encoding, address view and stage types for the data cache.

package dcache_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_SIZE    = DATA_WIDTH / 8;
    localparam int LINE_SIZE    = 16;
    localparam int LINE_WIDTH   = LINE_SIZE * 8;
    localparam int LINE_WORDS   = LINE_SIZE / DATA_SIZE;
    localparam int CACHE_SIZE   = 256;
    localparam int LINE_COUNT   = CACHE_SIZE / LINE_SIZE;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int INDEX_WIDTH  = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [2:0] {
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw
    } dc_op_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } dc_addr_fields_t;

    // same address word, seen raw or split for lookup.
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        dc_addr_fields_t       fields;
    } dc_addr_t;

    typedef struct packed {
        logic                  valid;
        dc_op_t                op;
        dc_addr_t              addr;
        logic [DATA_WIDTH-1:0] data;
    } dc_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } dc_rsp_t;

    typedef struct packed {
        logic                  valid;
        dc_op_t                op;
        dc_addr_t              addr;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_SIZE-1:0]  byte_sel;
        logic                  fill;
        logic [LINE_WIDTH-1:0] fill_data;
    } dc_stage_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } dc_line_state_t;

    typedef struct packed {
        logic                  victim_dirty;
        dc_addr_t              victim_addr;
        dc_addr_t              miss_addr;
        logic [LINE_WIDTH-1:0] victim_line;
    } dc_fill_req_t;

endpackage

// ==== src/dcache_rams.sv ====
// dcache arrays
// direct-mapped tag, valid, dirty and data arrays with a registered read.

`timescale 1ns/1ns

module dcache_rams (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  i_rd_index,
    input  logic                                i_hold,
    input  logic                                i_wr_en,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  i_wr_index,
    input  dcache_pkg::dc_line_state_t          i_wr_state,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_wr_line,
    output dcache_pkg::dc_line_state_t          o_state,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   o_line,
    output logic                                o_init_busy
);

    import dcache_pkg::*;

    logic                   valid_mem [LINE_COUNT];
    logic                   dirty_mem [LINE_COUNT];
    logic [TAG_WIDTH-1:0]   tag_mem   [LINE_COUNT];
    logic [LINE_WIDTH-1:0]  data_mem  [LINE_COUNT];
    logic [INDEX_WIDTH-1:0] init_index;

    // walker clears one valid bit per cycle after reset.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_init_busy <= 1'b1;
            init_index  <= '0;
        end else if (o_init_busy) begin
            init_index <= init_index + 1'b1;
            if (&init_index) begin
                o_init_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_init_busy) begin
            valid_mem[init_index] <= 1'b0;
        end else if (i_wr_en) begin
            valid_mem[i_wr_index] <= i_wr_state.valid;
            dirty_mem[i_wr_index] <= i_wr_state.dirty;
            tag_mem[i_wr_index]   <= i_wr_state.tag;
            data_mem[i_wr_index]  <= i_wr_line;
        end
    end

    // no write bypass.
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_state.valid <= valid_mem[i_rd_index];
            o_state.dirty <= dirty_mem[i_rd_index];
            o_state.tag   <= tag_mem[i_rd_index];
            o_line        <= data_mem[i_rd_index];
        end
    end

endmodule

// ==== verif/dcache_properties.sv ====
// dcache properties
// bound checks on the wishbone handshake, reset and stall rules.

`timescale 1ns/1ns

module dcache_properties (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                o_ready,
    input  dcache_pkg::dc_rsp_t                 o_rsp,
    input  logic                                o_wb_cyc,
    input  logic                                o_wb_stb,
    input  logic                                o_wb_we,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]   o_wb_adr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]   o_wb_dat,
    input  logic [dcache_pkg::DATA_SIZE-1:0]    o_wb_sel,
    input  logic                                i_wb_ack,
    input  logic                                i_fill_busy
);

    // master holds the beat until the slave acks.
    wb_hold: assert property (@(posedge clk) disable iff (i_rst)
        o_wb_stb && !i_wb_ack |=>
            $stable({o_wb_cyc, o_wb_stb, o_wb_we, o_wb_adr, o_wb_dat, o_wb_sel}))
        else $error("wishbone signals changed while waiting for ack");

    stb_in_cyc: assert property (@(posedge clk) disable iff (i_rst)
        o_wb_stb |-> o_wb_cyc)
        else $error("wishbone strobe raised outside a cycle");

    rsp_in_reset: assert property (@(posedge clk)
        i_rst && $past(i_rst) |-> !o_rsp.valid)
        else $error("response valid while in reset");

    ready_in_fill: assert property (@(posedge clk) disable iff (i_rst)
        i_fill_busy |-> !o_ready)
        else $error("cache ready while a line fill is busy");

endmodule

bind dcache dcache_properties u_props (
    .clk(clk), .i_rst(i_rst), .o_ready(o_ready), .o_rsp(o_rsp),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
    .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel),
    .i_wb_ack(i_wb_ack), .i_fill_busy(o_wb_cyc)
);

// ==== verif/dcache_tb.sv ====
// dcache testbench
// table of loads and stores checked against a shadow memory image.

`timescale 1ns/1ns

module dcache_tb;

    import dcache_pkg::*;

    localparam int NUM_REQS  = 21;
    localparam int MEM_BYTES = 1024;

    typedef struct packed {
        dc_req_t req;
        logic    evict;
    } stim_t;

    logic                  clk;
    logic                  i_rst;
    dc_req_t               i_req;
    logic                  o_ready;
    dc_rsp_t               o_rsp;
    logic                  o_wb_cyc;
    logic                  o_wb_stb;
    logic                  o_wb_we;
    logic [ADDR_WIDTH-1:0] o_wb_adr;
    logic [DATA_WIDTH-1:0] o_wb_dat;
    logic [DATA_SIZE-1:0]  o_wb_sel;
    logic [DATA_WIDTH-1:0] i_wb_dat;
    logic                  i_wb_ack;
    logic [DATA_WIDTH-1:0] mem [MEM_BYTES/DATA_SIZE];
    logic [7:0]            shadow [MEM_BYTES];
    int unsigned           ack_delay [256];
    stim_t                 stim [NUM_REQS];
    dc_rsp_t               exp_q [$];
    dc_rsp_t               exp_rsp;
    logic                  accepted_any;
    int                    ack_wait;
    int                    beat_count;
    int                    wb_writes;
    int                    exp_writes;

    dcache dut (
        .clk(clk), .i_rst(i_rst), .i_req(i_req), .o_ready(o_ready), .o_rsp(o_rsp),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
    );

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic stim_t make_entry(dc_op_t op, logic [ADDR_WIDTH-1:0] adr,
                                         logic [DATA_WIDTH-1:0] dat, logic evict);
        stim_t s;
        s.req.valid    = 1'b1;
        s.req.op       = op;
        s.req.addr.raw = adr;
        s.req.data     = dat;
        s.evict        = evict;
        return s;
    endfunction

    // little-endian read of the image, extended by op.
    function automatic logic [DATA_WIDTH-1:0] shadow_value(dc_op_t op, dc_addr_t a);
        int unsigned           p;
        logic [DATA_WIDTH-1:0] w;
        p = a.raw[9:0];
        for (int k = 0; k < DATA_SIZE; k++) begin
            w[k*8 +: 8] = shadow[(p + k) % MEM_BYTES];
        end
        case (op)
            op_lb:   return {{24{w[7]}}, w[7:0]};
            op_lbu:  return {24'b0, w[7:0]};
            op_lh:   return {{16{w[15]}}, w[15:0]};
            op_lhu:  return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic apply_store(dc_req_t r);
        int unsigned p;
        int unsigned n;
        p = r.addr.raw[9:0];
        case (r.op)
            op_sb:   n = 1;
            op_sh:   n = 2;
            default: n = 4;
        endcase
        for (int k = 0; k < n; k++) begin
            shadow[(p + k) % MEM_BYTES] = r.data[k*8 +: 8];
        end
    endtask

    task automatic check_rsp(dc_rsp_t got, dc_rsp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: load response %h, expected %h",
                               $time, got.data, exp.data));
        end
    endtask

    task automatic check_wb_write(dc_addr_t adr, logic [DATA_WIDTH-1:0] got);
        logic [DATA_WIDTH-1:0] exp;
        exp = shadow_value(op_lw, adr);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: write-back to %h data %h, expected %h",
                               $time, adr.raw, got, exp));
        end
    endtask

    // every beat moves a full word.
    task automatic check_wb_sel(logic [DATA_SIZE-1:0] got);
        if (got !== '1) begin
            stop_run($sformatf("[FAIL] %0t: wishbone byte select %b, expected all ones",
                               $time, got));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_REQS * 200) @(posedge clk);
        stop_run($sformatf("timeout, run did not finish in %0d cycles", NUM_REQS * 200));
    end

    // op, address, store data, dirty victim expected.
    initial begin
        stim[0]  = make_entry(op_lw,  32'h000, 32'h0, 1'b0);
        stim[1]  = make_entry(op_lb,  32'h001, 32'h0, 1'b0);
        stim[2]  = make_entry(op_lbu, 32'h003, 32'h0, 1'b0);
        stim[3]  = make_entry(op_lh,  32'h002, 32'h0, 1'b0);
        stim[4]  = make_entry(op_lhu, 32'h00e, 32'h0, 1'b0);
        stim[5]  = make_entry(op_lw,  32'h00c, 32'h0, 1'b0);
        stim[6]  = make_entry(op_sb,  32'h005, 32'h1234_5680, 1'b0);
        stim[7]  = make_entry(op_lw,  32'h004, 32'h0, 1'b0);
        stim[8]  = make_entry(op_sh,  32'h106, 32'hdead_beef, 1'b1);
        stim[9]  = make_entry(op_lh,  32'h106, 32'h0, 1'b0);
        stim[10] = make_entry(op_lw,  32'h104, 32'h0, 1'b0);
        stim[11] = make_entry(op_sw,  32'h238, 32'h1234_5678, 1'b0);
        stim[12] = make_entry(op_lbu, 32'h23a, 32'h0, 1'b0);
        stim[13] = make_entry(op_lw,  32'h030, 32'h0, 1'b1);
        stim[14] = make_entry(op_lb,  32'h006, 32'h0, 1'b1);
        stim[15] = make_entry(op_lw,  32'h238, 32'h0, 1'b0);
        stim[16] = make_entry(op_lhu, 32'h3f2, 32'h0, 1'b0);
        stim[17] = make_entry(op_lh,  32'h3f0, 32'h0, 1'b0);
        stim[18] = make_entry(op_lw,  32'h0f0, 32'h0, 1'b0);
        stim[19] = make_entry(op_sw,  32'h0f4, 32'hcafe_f00d, 1'b0);
        stim[20] = make_entry(op_lw,  32'h0f4, 32'h0, 1'b0);
    end

    // slave memory, ack after 0 to 3 idle cycles.
    always @(negedge clk) begin
        if (i_wb_ack) begin
            i_wb_ack = 1'b0;
        end else if (o_wb_cyc && o_wb_stb) begin
            if (ack_wait < 0) begin
                ack_wait = ack_delay[beat_count % 256];
                beat_count++;
            end
            if (ack_wait == 0) begin
                if (o_wb_adr >= MEM_BYTES) begin
                    stop_run("wishbone address outside the memory model");
                end
                check_wb_sel(o_wb_sel);
                if (o_wb_we) begin
                    check_wb_write(o_wb_adr, o_wb_dat);
                    mem[o_wb_adr[9:2]] = o_wb_dat;
                    wb_writes++;
                end else begin
                    i_wb_dat = mem[o_wb_adr[9:2]];
                end
                i_wb_ack = 1'b1;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (!accepted_any && o_wb_cyc === 1'b1) begin
            stop_run("wishbone cycle started before any request was accepted");
        end
        if (o_rsp.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_run("load response returned with no load outstanding");
            end else begin
                exp_rsp = exp_q.pop_front();
                check_rsp(o_rsp, exp_rsp);
            end
        end
    end

    initial begin
        logic [DATA_WIDTH-1:0] w;
        dc_rsp_t               e;
        void'($urandom(86332));
        i_rst        = 1'b1;
        i_req        = '0;
        i_wb_dat     = '0;
        i_wb_ack     = 1'b0;
        accepted_any = 1'b0;
        ack_wait     = -1;
        beat_count   = 0;
        wb_writes    = 0;
        exp_writes   = 0;
        for (int i = 0; i < MEM_BYTES / DATA_SIZE; i++) begin
            w = $urandom;
            mem[i] = w;
            for (int k = 0; k < DATA_SIZE; k++) begin
                shadow[i*DATA_SIZE + k] = w[k*8 +: 8];
            end
        end
        for (int i = 0; i < 256; i++) begin
            ack_delay[i] = $urandom_range(3, 0);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (int n = 0; n < NUM_REQS; n++) begin
            @(negedge clk);
            i_req.valid = 1'b0;
            while (!o_ready) @(negedge clk);
            i_req        = stim[n].req;
            accepted_any = 1'b1;
            if (stim[n].evict) begin
                exp_writes += LINE_WORDS;
            end
            if (stim[n].req.op inside {op_sb, op_sh, op_sw}) begin
                apply_store(stim[n].req);
            end else begin
                e.valid = 1'b1;
                e.data  = shadow_value(stim[n].req.op, stim[n].req.addr);
                exp_q.push_back(e);
            end
        end
        @(negedge clk);
        i_req.valid = 1'b0;
        while (exp_q.size() != 0 || !o_ready) @(negedge clk);
        if (wb_writes == exp_writes) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run($sformatf("[FAIL] %0t: %0d wishbone writes, expected %0d",
                               $time, wb_writes, exp_writes));
        end
    end

endmodule
